/* Bender.yml */
package:
  name: exec_cluster

sources:
  - files:
      - source/cpu_types_pkg.sv
      - source/exec_bus_pkg.sv
      - source/exers.sv
      - source/scalu.sv
      - source/mcalu.sv
      - source/wb_arbiter.sv
      - source/exec_cluster.sv
  - target: test
    files:
      - verification/exec_cluster_asserts.sv
      - verification/exec_cluster_tb.sv

/* filelist.f */
source/cpu_types_pkg.sv
source/exec_bus_pkg.sv
source/exers.sv
source/scalu.sv
source/mcalu.sv
source/wb_arbiter.sv
source/exec_cluster.sv
verification/exec_cluster_asserts.sv
verification/exec_cluster_tb.sv

/* source/cpu_types_pkg.sv */
// Core widths and opcode encodings; opcodes with both top bits set are multi-cycle only
package cpu_types_pkg;

  localparam int ROBID_W = 8;
  localparam int PREG_W  = 6;
  localparam int WORD_W  = 32;
  localparam int OP_W    = 5;

  typedef logic [ROBID_W-1:0] robid_t;
  // Bit 5 set means a renamed destination that may wake dependents
  typedef logic [PREG_W-1:0]  preg_t;
  typedef logic [WORD_W-1:0]  word_t;
  typedef logic [OP_W-1:0]    op_t;

  // Single-cycle operations
  localparam op_t OP_ADD  = 5'b00000;
  localparam op_t OP_SUB  = 5'b00001;
  localparam op_t OP_AND  = 5'b00010;
  localparam op_t OP_OR   = 5'b00011;
  localparam op_t OP_XOR  = 5'b00100;
  localparam op_t OP_SLL  = 5'b00101;
  localparam op_t OP_SRL  = 5'b00110;
  localparam op_t OP_SLT  = 5'b00111;

  // Multi-cycle operations, mcalu only
  localparam op_t OP_MUL  = 5'b11000;
  localparam op_t OP_MULH = 5'b11001;

  localparam int RS_ENTRIES_DEFAULT = 8;
  localparam int MCALU_STAGES       = 3;

endpackage

/* source/exec_bus_pkg.sv */
// Execute-cluster bus formats; multiplies are unsigned and SLT compares signed operands
package exec_bus_pkg;

  // Renamed operation from dispatch
  // A waiting operand holds the producer robid in its low bits
  typedef struct packed {
    cpu_types_pkg::op_t    op;
    cpu_types_pkg::robid_t robid;
    cpu_types_pkg::preg_t  rd;
    logic                  op1ready;
    cpu_types_pkg::word_t  op1;
    logic                  op2ready;
    cpu_types_pkg::word_t  op2;
  } dispatch_t;

  // Operation sent from the station to a unit
  typedef struct packed {
    cpu_types_pkg::op_t    op;
    cpu_types_pkg::robid_t robid;
    cpu_types_pkg::preg_t  rd;
    cpu_types_pkg::word_t  op1;
    cpu_types_pkg::word_t  op2;
  } issue_t;

  // Unit result and writeback bus
  typedef struct packed {
    logic                  valid;
    cpu_types_pkg::robid_t robid;
    cpu_types_pkg::preg_t  rd;
    cpu_types_pkg::word_t  result;
  } wb_t;

  // Reference evaluation of one operation
  function automatic cpu_types_pkg::word_t eval_op(input cpu_types_pkg::op_t op,
                                                   input cpu_types_pkg::word_t a,
                                                   input cpu_types_pkg::word_t b);
    logic [2*cpu_types_pkg::WORD_W-1:0] prod;
    prod = {{cpu_types_pkg::WORD_W{1'b0}}, a} * {{cpu_types_pkg::WORD_W{1'b0}}, b};
    case (op)
      cpu_types_pkg::OP_ADD:  return a + b;
      cpu_types_pkg::OP_SUB:  return a - b;
      cpu_types_pkg::OP_AND:  return a & b;
      cpu_types_pkg::OP_OR:   return a | b;
      cpu_types_pkg::OP_XOR:  return a ^ b;
      cpu_types_pkg::OP_SLL:  return a << b[4:0];
      cpu_types_pkg::OP_SRL:  return a >> b[4:0];
      cpu_types_pkg::OP_SLT:  return {{(cpu_types_pkg::WORD_W-1){1'b0}}, $signed(a) < $signed(b)};
      cpu_types_pkg::OP_MUL:  return prod[cpu_types_pkg::WORD_W-1:0];
      cpu_types_pkg::OP_MULH: return prod[2*cpu_types_pkg::WORD_W-1:cpu_types_pkg::WORD_W];
      default:                return '0;
    endcase
  endfunction

endpackage

/* source/exec_cluster.sv */
// Execute cluster top; rename, ROB and register file live outside and flush empties everything
`timescale 1ns/1ps

module exec_cluster (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    flush,
  input  logic                    dispatch_write,
  input  exec_bus_pkg::dispatch_t dispatch,
  output logic                    dispatch_stall,
  output exec_bus_pkg::wb_t       wb
);

  exec_bus_pkg::issue_t issue;
  logic                 scalu_issue;
  logic                 mcalu_issue;
  logic                 scalu_stall;
  logic                 mcalu_stall;
  logic                 scalu_grant;
  logic                 mcalu_grant;
  exec_bus_pkg::wb_t    scalu_result;
  exec_bus_pkg::wb_t    mcalu_result;

  exers #(
    .RS_ENTRIES(cpu_types_pkg::RS_ENTRIES_DEFAULT)
  ) u_exers (
    .clk            (clk),
    .rst            (rst),
    .flush          (flush),
    .dispatch_write (dispatch_write),
    .dispatch       (dispatch),
    .dispatch_stall (dispatch_stall),
    .issue          (issue),
    .scalu_issue    (scalu_issue),
    .mcalu_issue    (mcalu_issue),
    .scalu_stall    (scalu_stall),
    .mcalu_stall    (mcalu_stall),
    .wb             (wb)
  );

  scalu u_scalu (
    .clk         (clk),
    .rst         (rst),
    .flush       (flush),
    .issue_valid (scalu_issue),
    .issue       (issue),
    .stall       (scalu_stall),
    .result      (scalu_result),
    .grant       (scalu_grant)
  );

  mcalu u_mcalu (
    .clk         (clk),
    .rst         (rst),
    .flush       (flush),
    .issue_valid (mcalu_issue),
    .issue       (issue),
    .stall       (mcalu_stall),
    .result      (mcalu_result),
    .grant       (mcalu_grant)
  );

  // Merged results feed both the outputs and station wakeup
  wb_arbiter u_wb_arbiter (
    .scalu_result (scalu_result),
    .mcalu_result (mcalu_result),
    .scalu_grant  (scalu_grant),
    .mcalu_grant  (mcalu_grant),
    .wb           (wb)
  );

endmodule

/* source/exers.sv */
// Reservation station; RS_ENTRIES must be a power of two and flush drops a same-cycle dispatch
`timescale 1ns/1ps

module exers #(
  parameter int RS_ENTRIES = cpu_types_pkg::RS_ENTRIES_DEFAULT
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    flush,

  // Dispatch side
  input  logic                    dispatch_write,
  input  exec_bus_pkg::dispatch_t dispatch,
  output logic                    dispatch_stall,

  // Shared issue bus and per-unit strobes
  output exec_bus_pkg::issue_t    issue,
  output logic                    scalu_issue,
  output logic                    mcalu_issue,
  input  logic                    scalu_stall,
  input  logic                    mcalu_stall,

  // Writeback for operand wakeup
  input  exec_bus_pkg::wb_t       wb
);

  localparam int IDX_W = (RS_ENTRIES > 1) ? $clog2(RS_ENTRIES) : 1;

  logic [RS_ENTRIES-1:0]   rs_valid;
  exec_bus_pkg::dispatch_t rs_entry [RS_ENTRIES];
  logic [RS_ENTRIES-1:0]   rs_ready;

  logic [IDX_W-1:0] issue_idx;
  logic [IDX_W-1:0] free_idx;
  logic [IDX_W-1:0] insert_idx;
  logic             any_ready;
  logic             rs_full;
  logic             is_sc_op;
  logic             issued;
  logic             accept;

  // Capture a writeback result into any operand waiting on its tag
  function automatic exec_bus_pkg::dispatch_t wake(input exec_bus_pkg::dispatch_t e,
                                                   input exec_bus_pkg::wb_t w);
    exec_bus_pkg::dispatch_t r;
    logic                    hit;
    r   = e;
    hit = w.valid & w.rd[5];
    if (hit && !e.op1ready && (e.op1[cpu_types_pkg::ROBID_W-1:0] == w.robid)) begin
      r.op1ready = 1'b1;
      r.op1      = w.result;
    end
    if (hit && !e.op2ready && (e.op2[cpu_types_pkg::ROBID_W-1:0] == w.robid)) begin
      r.op2ready = 1'b1;
      r.op2      = w.result;
    end
    return r;
  endfunction

  always_comb begin
    for (int i = 0; i < RS_ENTRIES; i++) begin
      rs_ready[i] = rs_valid[i] & rs_entry[i].op1ready & rs_entry[i].op2ready;
    end
  end

  // Lowest ready entry and lowest free slot
  always_comb begin
    any_ready = 1'b0;
    issue_idx = '0;
    free_idx  = '0;
    for (int i = RS_ENTRIES - 1; i >= 0; i--) begin
      if (rs_ready[i]) begin
        any_ready = 1'b1;
        issue_idx = IDX_W'(i);
      end
      if (!rs_valid[i]) begin
        free_idx = IDX_W'(i);
      end
    end
  end

  assign rs_full = &rs_valid;

  // Issue bus straight from the selected entry
  always_comb begin
    issue.op    = rs_entry[issue_idx].op;
    issue.robid = rs_entry[issue_idx].robid;
    issue.rd    = rs_entry[issue_idx].rd;
    issue.op1   = rs_entry[issue_idx].op1;
    issue.op2   = rs_entry[issue_idx].op2;
  end

  // Multi-cycle ops have both top opcode bits set
  assign is_sc_op = ~&rs_entry[issue_idx].op[cpu_types_pkg::OP_W-1:cpu_types_pkg::OP_W-2];

  // scalu first for single-cycle ops, mcalu takes anything
  assign scalu_issue = any_ready & is_sc_op & ~scalu_stall;
  assign mcalu_issue = any_ready & ~scalu_issue & ~mcalu_stall;
  assign issued      = scalu_issue | mcalu_issue;

  // When full, the slot freed by this cycle's issue takes the new op
  assign insert_idx     = rs_full ? issue_idx : free_idx;
  assign dispatch_stall = rs_full & ~issued;
  assign accept         = dispatch_write & ~dispatch_stall;

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      rs_valid <= '0;
    end else begin
      if (issued) begin
        rs_valid[issue_idx] <= 1'b0;
      end
      // Insertion last so a reused slot stays valid
      if (accept) begin
        rs_valid[insert_idx] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < RS_ENTRIES; i++) begin
      rs_entry[i] <= wake(rs_entry[i], wb);
    end
    // Incoming op also sees this cycle's writeback
    if (accept) begin
      rs_entry[insert_idx] <= wake(dispatch, wb);
    end
  end

endmodule

/* source/mcalu.sv */
// Three-stage execute pipeline; multiplies are unsigned 16-bit partial products summed in stage 2
`timescale 1ns/1ps

module mcalu (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 flush,
  input  logic                 issue_valid,
  input  exec_bus_pkg::issue_t issue,
  output logic                 stall,
  output exec_bus_pkg::wb_t    result,
  input  logic                 grant
);

  localparam int LAST = cpu_types_pkg::MCALU_STAGES - 1;

  typedef struct packed {
    cpu_types_pkg::op_t    op;
    cpu_types_pkg::robid_t robid;
    cpu_types_pkg::preg_t  rd;
    cpu_types_pkg::word_t  alu;
    cpu_types_pkg::word_t  pp_ll;
    cpu_types_pkg::word_t  pp_lh;
    cpu_types_pkg::word_t  pp_hl;
    cpu_types_pkg::word_t  pp_hh;
  } stage1_t;

  typedef struct packed {
    cpu_types_pkg::op_t                 op;
    cpu_types_pkg::robid_t              robid;
    cpu_types_pkg::preg_t               rd;
    cpu_types_pkg::word_t               alu;
    logic [2*cpu_types_pkg::WORD_W-1:0] prod;
  } stage2_t;

  typedef struct packed {
    cpu_types_pkg::robid_t robid;
    cpu_types_pkg::preg_t  rd;
    cpu_types_pkg::word_t  value;
  } stage3_t;

  logic [LAST:0] vld;
  logic [LAST:0] ld;
  stage1_t       s1;
  stage2_t       s2;
  stage3_t       s3;

  // A stage loads when empty or when the stage ahead frees
  always_comb begin
    ld[LAST] = ~vld[LAST] | grant;
    for (int i = LAST - 1; i >= 0; i--) begin
      ld[i] = ~vld[i] | ld[i+1];
    end
  end

  assign stall = ~ld[0];

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      vld <= '0;
    end else begin
      if (ld[0]) begin
        vld[0] <= issue_valid;
      end
      for (int i = 1; i <= LAST; i++) begin
        if (ld[i]) begin
          vld[i] <= vld[i-1];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    // Stage 1 partial products and ALU result
    if (ld[0] && issue_valid) begin
      s1.op    <= issue.op;
      s1.robid <= issue.robid;
      s1.rd    <= issue.rd;
      s1.alu   <= exec_bus_pkg::eval_op(issue.op, issue.op1, issue.op2);
      s1.pp_ll <= issue.op1[15:0] * issue.op2[15:0];
      s1.pp_lh <= issue.op1[15:0] * issue.op2[31:16];
      s1.pp_hl <= issue.op1[31:16] * issue.op2[15:0];
      s1.pp_hh <= issue.op1[31:16] * issue.op2[31:16];
    end
    // Stage 2 full 64-bit product
    if (ld[1] && vld[0]) begin
      s2.op    <= s1.op;
      s2.robid <= s1.robid;
      s2.rd    <= s1.rd;
      s2.alu   <= s1.alu;
      s2.prod  <= {s1.pp_hh, s1.pp_ll} + ({32'b0, s1.pp_lh} << 16) + ({32'b0, s1.pp_hl} << 16);
    end
    // Stage 3 picks the result half
    if (ld[2] && vld[1]) begin
      s3.robid <= s2.robid;
      s3.rd    <= s2.rd;
      case (s2.op)
        cpu_types_pkg::OP_MUL:  s3.value <= s2.prod[31:0];
        cpu_types_pkg::OP_MULH: s3.value <= s2.prod[63:32];
        default:                s3.value <= s2.alu;
      endcase
    end
  end

  assign result.valid  = vld[LAST];
  assign result.robid  = s3.robid;
  assign result.rd     = s3.rd;
  assign result.result = s3.value;

endmodule

/* source/scalu.sv */
// Single-cycle ALU; expects only single-cycle ops and holds its result until granted
`timescale 1ns/1ps

module scalu (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 flush,
  input  logic                 issue_valid,
  input  exec_bus_pkg::issue_t issue,
  output logic                 stall,
  output exec_bus_pkg::wb_t    result,
  input  logic                 grant
);

  logic                  res_valid;
  cpu_types_pkg::robid_t res_robid;
  cpu_types_pkg::preg_t  res_rd;
  cpu_types_pkg::word_t  res_value;
  logic                  load;

  // Register free or its content leaving this cycle
  assign load  = ~res_valid | grant;
  assign stall = ~load;

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      res_valid <= 1'b0;
    end else if (load) begin
      res_valid <= issue_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (load && issue_valid) begin
      res_robid <= issue.robid;
      res_rd    <= issue.rd;
      res_value <= exec_bus_pkg::eval_op(issue.op, issue.op1, issue.op2);
    end
  end

  assign result.valid  = res_valid;
  assign result.robid  = res_robid;
  assign result.rd     = res_rd;
  assign result.result = res_value;

endmodule

/* source/wb_arbiter.sv */
// Writeback arbiter; fixed priority to scalu so mcalu waits while scalu holds a result
`timescale 1ns/1ps

module wb_arbiter (
  input  exec_bus_pkg::wb_t scalu_result,
  input  exec_bus_pkg::wb_t mcalu_result,
  output logic              scalu_grant,
  output logic              mcalu_grant,
  output exec_bus_pkg::wb_t wb
);

  // scalu wins any cycle it has a result
  assign scalu_grant = scalu_result.valid;

  // mcalu only when scalu is idle
  assign mcalu_grant = ~scalu_result.valid & mcalu_result.valid;

  // Idle mcalu result carries valid low, so the bus goes quiet
  always_comb begin
    if (scalu_grant) begin
      wb = scalu_result;
    end else begin
      wb = mcalu_result;
    end
  end

endmodule

/* verification/exec_cluster_asserts.sv */
// Handshake checks bound at the cluster top, which holds both the station and arbiter nets
`timescale 1ns/1ps

module exec_cluster_asserts (
  input logic                 clk,
  input logic                 rst,
  input logic                 scalu_issue,
  input logic                 mcalu_issue,
  input exec_bus_pkg::issue_t issue,
  input logic                 scalu_grant,
  input logic                 mcalu_grant,
  input exec_bus_pkg::wb_t    wb
);

  logic rst_d;

  // Delayed reset so the first edge is not checked
  always_ff @(posedge clk) begin
    rst_d <= rst;
  end

  a_one_issue: assert property (@(posedge clk) disable iff (rst)
    !(scalu_issue && mcalu_issue))
    else $error("both issue strobes high");

  // Multi-cycle ops have both top opcode bits set
  a_scalu_class: assert property (@(posedge clk) disable iff (rst)
    scalu_issue |-> !(&issue.op[cpu_types_pkg::OP_W-1:cpu_types_pkg::OP_W-2]))
    else $error("multi-cycle op issued to scalu");

  a_wb_reset: assert property (@(posedge clk)
    (rst && rst_d) |-> !wb.valid)
    else $error("writeback valid during reset");

  a_one_grant: assert property (@(posedge clk) disable iff (rst)
    !(scalu_grant && mcalu_grant))
    else $error("both grants high");

endmodule

bind exec_cluster exec_cluster_asserts u_asserts (
  .clk         (clk),
  .rst         (rst),
  .scalu_issue (scalu_issue),
  .mcalu_issue (mcalu_issue),
  .issue       (issue),
  .scalu_grant (scalu_grant),
  .mcalu_grant (mcalu_grant),
  .wb          (wb)
);

/* verification/exec_cluster_tb.sv */
// Cluster testbench; robids are reused only after their earlier writeback, so the scoreboard keys on robid
`timescale 1ns/1ps

module exec_cluster_tb;

  // One dispatch row; a waiting operand carries the producer tag in v1 or v2
  typedef struct packed {
    cpu_types_pkg::op_t    op;
    cpu_types_pkg::robid_t robid;
    cpu_types_pkg::preg_t  rd;
    logic                  r1;
    cpu_types_pkg::word_t  v1;
    logic                  r2;
    cpu_types_pkg::word_t  v2;
    logic                  drain;
    logic                  flush;
  } row_t;

  logic                    clk;
  logic                    rst;
  logic                    flush;
  logic                    dispatch_write;
  exec_bus_pkg::dispatch_t dispatch;
  logic                    dispatch_stall;
  exec_bus_pkg::wb_t       wb;

  row_t                 table_q [$];
  row_t                 pend [256];
  logic                 outstanding [256];
  logic                 wake_done [256];
  cpu_types_pkg::word_t prod_val [256];
  int                   open_count;
  int                   cycles;
  int                   cycle_limit;
  logic                 stall_seen;

  exec_cluster DUT (
    .clk            (clk),
    .rst            (rst),
    .flush          (flush),
    .dispatch_write (dispatch_write),
    .dispatch       (dispatch),
    .dispatch_stall (dispatch_stall),
    .wb             (wb)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  task automatic fail_now(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_value(input cpu_types_pkg::word_t actual,
                             input cpu_types_pkg::word_t expected,
                             input string what);
    if (actual !== expected) begin
      $display("Fail at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
      $display("Something failed");
      $fatal(1);
    end
  endtask

  task automatic add_row(input cpu_types_pkg::op_t op, input int robid, input int rd,
                         input logic r1, input cpu_types_pkg::word_t v1,
                         input logic r2, input cpu_types_pkg::word_t v2,
                         input logic drain, input logic flush_first);
    row_t r;
    r = '{op: op, robid: robid[7:0], rd: rd[5:0], r1: r1, v1: v1, r2: r2, v2: v2,
          drain: drain, flush: flush_first};
    table_q.push_back(r);
  endtask

  task automatic build_table();
    cpu_types_pkg::op_t sc_ops [8];
    sc_ops = '{cpu_types_pkg::OP_ADD, cpu_types_pkg::OP_SUB, cpu_types_pkg::OP_AND,
               cpu_types_pkg::OP_OR, cpu_types_pkg::OP_XOR, cpu_types_pkg::OP_SLL,
               cpu_types_pkg::OP_SRL, cpu_types_pkg::OP_SLT};
    // Every single-cycle opcode with ready operands
    for (int i = 0; i < 8; i++) begin
      add_row(sc_ops[i], 1 + i, 6'h20 | i, 1, $urandom(), 1, $urandom(), 0, 0);
    end
    // Back to back multiplies
    for (int i = 0; i < 6; i++) begin
      add_row(i[0] ? cpu_types_pkg::OP_MULH : cpu_types_pkg::OP_MUL, 10 + i, 6'h30,
              1, $urandom(), 1, $urandom(), 0, 0);
    end
    // Dependents on a waking producer
    add_row(cpu_types_pkg::OP_ADD, 20, 6'h21, 1, $urandom(), 1, $urandom(), 0, 0);
    add_row(cpu_types_pkg::OP_SUB, 21, 6'h22, 0, 32'd20, 1, $urandom(), 0, 0);
    add_row(cpu_types_pkg::OP_MUL, 22, 6'h23, 1, $urandom(), 0, 32'd20, 0, 0);
    // Producer with rd bit 5 clear must not wake robid 31
    add_row(cpu_types_pkg::OP_XOR, 31, 6'h24, 0, 32'd30, 1, $urandom(), 0, 0);
    add_row(cpu_types_pkg::OP_XOR, 30, 6'h05, 1, $urandom(), 1, $urandom(), 0, 0);
    add_row(cpu_types_pkg::OP_OR, 30, 6'h26, 1, $urandom(), 1, $urandom(), 1, 0);
    // Burst that fills the station with waiting ops
    for (int i = 0; i < 7; i++) begin
      add_row(i[0] ? cpu_types_pkg::OP_MUL : cpu_types_pkg::OP_ADD, 40 + i, 6'h27,
              0, 32'd50, 1, $urandom(), 0, 0);
    end
    add_row(cpu_types_pkg::OP_MUL, 50, 6'h28, 1, $urandom(), 1, $urandom(), 0, 0);
    for (int i = 0; i < 4; i++) begin
      add_row(i[0] ? cpu_types_pkg::OP_SLT : cpu_types_pkg::OP_MULH, 51 + i, 6'h29,
              1, $urandom(), 0, 32'd60, 0, 0);
    end
    add_row(cpu_types_pkg::OP_SUB, 60, 6'h2a, 1, $urandom(), 1, $urandom(), 0, 0);
    // Mixed traffic so both units finish together
    // An ADD issued two cycles after a MUL lands on the same writeback cycle
    for (int i = 0; i < 10; i++) begin
      add_row((i % 3 == 0) ? cpu_types_pkg::OP_MUL : cpu_types_pkg::OP_ADD, 70 + i, 6'h2b,
              1, $urandom(), 1, $urandom(), 0, 0);
    end
    // Flush with a multiply in flight and an op that never wakes
    add_row(cpu_types_pkg::OP_MUL, 90, 6'h2c, 1, $urandom(), 1, $urandom(), 0, 0);
    add_row(cpu_types_pkg::OP_AND, 91, 6'h2d, 1, $urandom(), 1, $urandom(), 0, 0);
    add_row(cpu_types_pkg::OP_ADD, 92, 6'h2e, 0, 32'd250, 1, $urandom(), 0, 0);
    add_row(cpu_types_pkg::OP_ADD, 93, 6'h2f, 1, $urandom(), 1, $urandom(), 0, 1);
    add_row(cpu_types_pkg::OP_MULH, 94, 6'h30, 1, $urandom(), 1, $urandom(), 0, 0);
    add_row(cpu_types_pkg::OP_SLT, 95, 6'h31, 0, 32'd93, 1, $urandom(), 0, 0);
  endtask

  // Drive one row and hold it until the station accepts it
  task automatic dispatch_row(input row_t r);
    logic stalled;
    while (r.drain && outstanding[r.robid]) begin
      @(posedge clk);
      #2;
    end
    if (r.flush) begin
      flush = 1'b1;
      @(posedge clk);
      #2;
      flush = 1'b0;
      for (int i = 0; i < 256; i++) begin
        if (outstanding[i]) begin
          outstanding[i] = 1'b0;
          open_count--;
        end
      end
    end
    dispatch       = '{op: r.op, robid: r.robid, rd: r.rd, op1ready: r.r1, op1: r.v1,
                       op2ready: r.r2, op2: r.v2};
    dispatch_write = 1'b1;
    do begin
      @(negedge clk);
      stalled = dispatch_stall;
      if (stalled) begin
        stall_seen = 1'b1;
      end
      @(posedge clk);
      #2;
    end while (stalled);
    dispatch_write     = 1'b0;
    pend[r.robid]      = r;
    outstanding[r.robid] = 1'b1;
    wake_done[r.robid] = 1'b0;
    open_count++;
    if (r.r1 && r.r2) begin
      prod_val[r.robid] = exec_bus_pkg::eval_op(r.op, r.v1, r.v2);
    end
  endtask

  // Scoreboard samples the writeback bus mid-cycle
  always @(negedge clk) begin : scoreboard
    row_t                 r;
    cpu_types_pkg::word_t a;
    cpu_types_pkg::word_t b;
    cpu_types_pkg::word_t exp_val;
    logic                 early;
    if (!rst && wb.valid) begin
      r     = pend[wb.robid];
      a     = r.v1;
      b     = r.v2;
      early = 1'b0;
      if (!r.r1) begin
        early = early | ~wake_done[r.v1[7:0]];
        a     = prod_val[r.v1[7:0]];
      end
      if (!r.r2) begin
        early = early | ~wake_done[r.v2[7:0]];
        b     = prod_val[r.v2[7:0]];
      end
      if (!outstanding[wb.robid]) begin
        fail_now($sformatf("writeback for robid %0d was duplicate or unexpected", wb.robid));
      end else if (early) begin
        fail_now($sformatf("robid %0d wrote back before its producer", wb.robid));
      end else begin
        exp_val = exec_bus_pkg::eval_op(r.op, a, b);
        check_value(wb.result, exp_val, $sformatf("result of robid %0d", wb.robid));
        check_value(32'(wb.rd), 32'(r.rd), $sformatf("rd of robid %0d", wb.robid));
        outstanding[wb.robid] = 1'b0;
        open_count--;
        prod_val[wb.robid] = exp_val;
        if (wb.rd[5]) begin
          wake_done[wb.robid] = 1'b1;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("Timeout after %0d cycles with %0d ops still open", cycles, open_count);
      $display("Something failed");
      $fatal(1);
    end
  end

  initial begin
    rst            = 1'b1;
    flush          = 1'b0;
    dispatch_write = 1'b0;
    dispatch       = '0;
    open_count     = 0;
    cycles         = 0;
    stall_seen     = 1'b0;
    cycle_limit    = 1000000;
    for (int i = 0; i < 256; i++) begin
      outstanding[i] = 1'b0;
      wake_done[i]   = 1'b0;
      prod_val[i]    = '0;
    end
    void'($urandom(32'h1cd8));
    build_table();
    cycle_limit = 20 * table_q.size() + 5;
    repeat (5) @(posedge clk);
    #2;
    rst = 1'b0;
    foreach (table_q[i]) begin
      dispatch_row(table_q[i]);
    end
    while (open_count != 0) begin
      @(posedge clk);
    end
    // Watch for stray results after the last expected one
    repeat (10) @(posedge clk);
    check_value(32'(stall_seen), 32'd1, "dispatch_stall seen during burst");
    $display("Everything OK");
    $finish;
  end

endmodule
